/* quarter_cos.hex */
// one column: cos(k*pi/128) in Q1.15 as 16 bit hex, k = 0..64
// entry 0 is saturated to 7FFF
7FFF
7FF6
7FD9
7FA7
7F62
7F0A
7E9D
7E1E
7D8A
7CE4
7C2A
7B5D
7A7D
798A
7885
776C
7642
7505
73B6
7255
70E3
6F5F
6DCA
6C24
6A6E
68A7
66D0
64E9
62F2
60EC
5ED7
5CB4
5A82
5843
55F6
539B
5134
4EC0
4C40
49B4
471D
447B
41CE
3F17
3C57
398D
36BA
33DF
30FC
2E11
2B1F
2827
2528
2224
1F1A
1C0C
18F9
15E2
12C8
0FAB
0C8C
096B
0648
0324
0000

/* compile.f */
fft_pkg.sv
twiddle_gen.sv
complex_mult.sv
butterfly_core.sv
fft_butterfly.sv
tb_fft_butterfly.sv

/* run.sh */
#!/bin/sh
# build and run the butterfly testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f compile.f --top-module tb_fft_butterfly -o sim_tb
status=0
output=$(./obj_dir/sim_tb 2>&1) || status=$?
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -q '^NO ERRORS$'; then
    exit 0
fi
echo "simulation failed, exit status $status"
exit 1

/* tb_fft_butterfly.sv */
/*
 Testbench for the radix-2 butterfly. Drives angle sweeps, random and gapped
 streams and full-scale samples, and checks x, y and out_valid against a model.
*/
module tb_fft_butterfly import fft_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 8;
    localparam int DRIVE_DELAY  = 1;
    localparam int RESET_CYCLES = 3;
    localparam int IDLE_CYCLES  = 4;
    localparam int SWEEP_N      = 256;
    localparam int RANDOM_N     = 300;
    localparam int GAP_CYCLES   = 200;
    localparam int EXTREME_N    = 64;
    localparam int TOTAL_ITEMS  = IDLE_CYCLES + SWEEP_N + RANDOM_N + GAP_CYCLES + EXTREME_N + 1;
    localparam int WATCHDOG_CYCLES = TOTAL_ITEMS + RESET_CYCLES + PIPE_LATENCY + 20;

    localparam sample_t S_MAX = 16'sh7FFF;
    localparam sample_t S_MIN = 16'sh8000;

    typedef struct packed {
        cplx_sum_t  x;
        cplx_prod_t y;
    } result_t;

    typedef struct packed {
        int      due;
        result_t res;
    } pending_t;

    // starts low without an edge at time zero
    logic       clk = 1'b0;
    logic       reset;
    logic       in_valid;
    cplx_t      a;
    cplx_t      b;
    angle_t     angle;
    logic       out_valid;
    cplx_sum_t  x;
    cplx_prod_t y;

    sample_t  cos_ref [TABLE_DEPTH];
    pending_t expected_q [$];
    int       cycle = 0;
    bit       seen_output = 1'b0;

    fft_butterfly dut_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .angle     (angle),
        .out_valid (out_valid),
        .x         (x),
        .y         (y)
    );

    //////////////////////////////
    // clock and cycle count

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    //////////////////////////////
    // reference model and checks

    function automatic result_t expected_result(input cplx_t a_v, input cplx_t b_v,
                                                input angle_t ang);
        int                      k;
        int                      q;
        int                      c_k;
        int                      c_c;
        int                      w_re;
        int                      w_im;
        int                      d_re;
        int                      d_im;
        logic [TABLE_ADDR_W-1:0] idx_k;
        logic [TABLE_ADDR_W-1:0] idx_c;
        longint                  acc_re;
        longint                  acc_im;
        result_t                 r;
        k     = int'(ang[OFFSET_W-1:0]);
        q     = int'(ang[ANGLE_W-1:OFFSET_W]);
        idx_k = TABLE_ADDR_W'(k);
        idx_c = TABLE_ADDR_W'(QUARTER - k);
        c_k   = int'(cos_ref[idx_k]);
        c_c   = int'(cos_ref[idx_c]);
        // rotate the first quadrant pair by q quarter turns
        case (q)
            0: begin
                w_re = c_k;
                w_im = c_c;
            end
            1: begin
                w_re = -c_c;
                w_im = c_k;
            end
            2: begin
                w_re = -c_k;
                w_im = -c_c;
            end
            default: begin
                w_re = c_c;
                w_im = -c_k;
            end
        endcase
        d_re   = int'(a_v.re) - int'(b_v.re);
        d_im   = int'(a_v.im) - int'(b_v.im);
        r.x.re = sum_t'(int'(a_v.re) + int'(b_v.re));
        r.x.im = sum_t'(int'(a_v.im) + int'(b_v.im));
        acc_re = longint'(d_re) * longint'(w_re) - longint'(d_im) * longint'(w_im);
        acc_im = longint'(d_re) * longint'(w_im) + longint'(d_im) * longint'(w_re);
        r.y.re = prod_t'(acc_re >>> FRAC_BITS);
        r.y.im = prod_t'(acc_im >>> FRAC_BITS);
        return r;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_sum(input string field, input cplx_sum_t exp, input cplx_sum_t act);
        if (exp !== act) begin
            abort_run($sformatf("error %0t: %s expected (%0d, %0d) got (%0d, %0d)",
                                $time, field, exp.re, exp.im, act.re, act.im));
        end
    endtask

    task automatic check_prod(input string field, input cplx_prod_t exp, input cplx_prod_t act);
        if (exp !== act) begin
            abort_run($sformatf("error %0t: %s expected (%0d, %0d) got (%0d, %0d)",
                                $time, field, exp.re, exp.im, act.re, act.im));
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin : compare_outputs
        pending_t head;
        if (out_valid && expected_q.size() == 0) begin
            abort_run($sformatf("out_valid went high at %0t with no item in flight", $time));
        end else if (out_valid) begin
            head        = expected_q.pop_front();
            seen_output = 1'b1;
            if (head.due != cycle) begin
                abort_run($sformatf("out_valid at %0t came in cycle %0d, item was due in %0d",
                                    $time, cycle, head.due));
            end else begin
                check_sum("x", head.res.x, x);
                check_prod("y", head.res.y, y);
            end
        end else if (expected_q.size() != 0 && expected_q[0].due == cycle) begin
            abort_run($sformatf("out_valid stayed low at %0t while an item was due", $time));
        end else if (!seen_output) begin
            check_sum("x before first out_valid", '0, x);
            check_prod("y before first out_valid", '0, y);
        end
    end

    //////////////////////////////
    // stimulus

    function automatic cplx_t random_cplx();
        cplx_t r;
        r.re = sample_t'($urandom());
        r.im = sample_t'($urandom());
        return r;
    endfunction

    task automatic drive_cycle(input logic valid, input cplx_t a_v, input cplx_t b_v,
                               input angle_t ang);
        pending_t item;
        @(posedge clk);
        #DRIVE_DELAY;
        in_valid = valid;
        a        = a_v;
        b        = b_v;
        angle    = ang;
        if (valid) begin
            item.due = cycle + PIPE_LATENCY;
            item.res = expected_result(a_v, b_v, ang);
            expected_q.push_back(item);
        end
    endtask

    initial begin
        cplx_t a_v;
        cplx_t b_v;
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(54));
        reset    = 1'b1;
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        angle    = '0;
        $readmemh(COS_TABLE_FILE, cos_ref);
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        repeat (IDLE_CYCLES) drive_cycle(1'b0, '0, '0, '0);

        // every angle with a fixed difference
        a_v.re = sample_t'(16384);
        a_v.im = '0;
        for (int i = 0; i < SWEEP_N; i++) begin
            drive_cycle(1'b1, a_v, '0, angle_t'(i));
        end

        // back to back random items
        for (int i = 0; i < RANDOM_N; i++) begin
            drive_cycle(1'b1, random_cplx(), random_cplx(), angle_t'($urandom()));
        end

        // valid strobe at about half rate
        for (int i = 0; i < GAP_CYCLES; i++) begin
            drive_cycle(($urandom() % 2) == 1, random_cplx(), random_cplx(),
                        angle_t'($urandom()));
        end

        // full scale corners at the four axis angles
        for (int m = 0; m < 16; m++) begin
            for (int q = 0; q < 4; q++) begin
                a_v.re = m[0] ? S_MIN : S_MAX;
                a_v.im = m[1] ? S_MIN : S_MAX;
                b_v.re = m[2] ? S_MIN : S_MAX;
                b_v.im = m[3] ? S_MIN : S_MAX;
                drive_cycle(1'b1, a_v, b_v, angle_t'(q * QUARTER));
            end
        end

        drive_cycle(1'b0, '0, '0, '0);
        repeat (PIPE_LATENCY) @(posedge clk);
        #DRIVE_DELAY;
        if (expected_q.size() != 0) begin
            abort_run($sformatf("%0d items never reached the outputs", expected_q.size()));
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run($sformatf("timeout: run did not finish within %0d clock cycles",
                            WATCHDOG_CYCLES));
    end

endmodule

/* fft_butterfly.sv */
/*
 Top level of the radix-2 FFT butterfly.
 x = a + b and y = (a - b) * W three cycles after in_valid.
*/
module fft_butterfly import fft_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    input  cplx_t      a,
    input  cplx_t      b,
    input  angle_t     angle,
    output logic       out_valid,
    output cplx_sum_t  x,
    output cplx_prod_t y
);

    // two cycles behind angle
    cplx_t twiddle;

    //////////////////////////////
    // twiddle from angle

    twiddle_gen twiddle_i (
        .clk     (clk),
        .reset   (reset),
        .angle   (angle),
        .twiddle (twiddle)
    );

    //////////////////////////////
    // datapath

    butterfly_core core_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .twiddle   (twiddle),
        .out_valid (out_valid),
        .x         (x),
        .y         (y)
    );

endmodule

/* butterfly_core.sv */
/*
 Butterfly datapath. Registers a+b and a-b, lines the difference up with
 the twiddle, multiplies, and carries a valid strobe alongside.
*/
module butterfly_core import fft_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    input  cplx_t      a,
    input  cplx_t      b,
    input  cplx_t      twiddle,
    output logic       out_valid,
    output cplx_sum_t  x,
    output cplx_prod_t y
);

    cplx_sum_t               sum_r;
    cplx_sum_t               diff_r;
    cplx_sum_t               sum_d;
    cplx_sum_t               diff_d;
    logic [PIPE_LATENCY-1:0] valid_pipe;

    //////////////////////////////
    // stage 1: sum and difference

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sum_r  <= '0;
            diff_r <= '0;
        end else begin
            // sign extend before the add
            sum_r.re  <= sum_t'(a.re) + sum_t'(b.re);
            sum_r.im  <= sum_t'(a.im) + sum_t'(b.im);
            diff_r.re <= sum_t'(a.re) - sum_t'(b.re);
            diff_r.im <= sum_t'(a.im) - sum_t'(b.im);
        end
    end

    //////////////////////////////
    // stage 2: wait for the twiddle

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sum_d  <= '0;
            diff_d <= '0;
        end else begin
            sum_d  <= sum_r;
            diff_d <= diff_r;
        end
    end

    //////////////////////////////
    // stage 3: multiply and output

    complex_mult mult_i (
        .clk     (clk),
        .reset   (reset),
        .diff    (diff_d),
        .twiddle (twiddle),
        .y       (y)
    );

    // x rides along with the product
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            x <= '0;
        end else begin
            x <= sum_d;
        end
    end

    // strobe delayed by the full latency
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[PIPE_LATENCY-2:0], in_valid};
        end
    end

    assign out_valid = valid_pipe[PIPE_LATENCY-1];

endmodule

/* complex_mult.sv */
/*
 Complex multiply of the butterfly difference by the twiddle.
 Result is rescaled by the twiddle fraction bits and registered.
*/
module complex_mult import fft_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  cplx_sum_t  diff,
    input  cplx_t      twiddle,
    output cplx_prod_t y
);

    //////////////////////////////
    // partial products

    logic signed [MULT_W-1:0] p_rr;
    logic signed [MULT_W-1:0] p_ii;
    logic signed [MULT_W-1:0] p_ri;
    logic signed [MULT_W-1:0] p_ir;

    assign p_rr = diff.re * twiddle.re;
    assign p_ii = diff.im * twiddle.im;
    assign p_ri = diff.re * twiddle.im;
    assign p_ir = diff.im * twiddle.re;

    //////////////////////////////
    // combine and rescale

    logic signed [ACC_W-1:0] acc_re;
    logic signed [ACC_W-1:0] acc_im;
    cplx_prod_t              y_c;

    // one guard bit for the add
    assign acc_re = p_rr - p_ii;
    assign acc_im = p_ri + p_ir;

    // arithmetic shift keeps the sign
    assign y_c.re = prod_t'(acc_re >>> FRAC_BITS);
    assign y_c.im = prod_t'(acc_im >>> FRAC_BITS);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            y <= '0;
        end else begin
            y <= y_c;
        end
    end

endmodule

/* twiddle_gen.sv */
/*
 Twiddle generator. Turns an 8 bit angle into W = cos + j*sin by folding
 one quarter wave cosine table. Two cycles from angle to twiddle.
*/
module twiddle_gen import fft_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  angle_t angle,
    output cplx_t  twiddle
);

    // cos(k*pi/128) for k = 0..64
    sample_t cos_table [TABLE_DEPTH];

    initial begin
        $readmemh(COS_TABLE_FILE, cos_table);
    end

    //////////////////////////////
    // stage 1: quadrant and addresses

    logic [OFFSET_W-1:0]     offset;
    quadrant_t               quad;
    quadrant_t               quad_r;
    logic [TABLE_ADDR_W-1:0] addr_k_r;
    logic [TABLE_ADDR_W-1:0] addr_c_r;

    assign offset = angle[OFFSET_W-1:0];
    assign quad   = quadrant_t'(angle[ANGLE_W-1:OFFSET_W]);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            quad_r   <= Q0;
            addr_k_r <= '0;
            addr_c_r <= TABLE_ADDR_W'(QUARTER);
        end else begin
            quad_r   <= quad;
            addr_k_r <= TABLE_ADDR_W'(offset);
            // complementary angle gives the sine
            addr_c_r <= TABLE_ADDR_W'(QUARTER) - TABLE_ADDR_W'(offset);
        end
    end

    //////////////////////////////
    // stage 2: read and fold

    sample_t t_k;
    sample_t t_c;
    cplx_t   twiddle_c;

    // two parallel reads of the same table
    assign t_k = cos_table[addr_k_r];
    assign t_c = cos_table[addr_c_r];

    // entry 0 is 7FFF so negation never overflows
    always_comb begin
        case (quad_r)
            Q0: begin
                twiddle_c.re = t_k;
                twiddle_c.im = t_c;
            end
            Q1: begin
                twiddle_c.re = -t_c;
                twiddle_c.im = t_k;
            end
            Q2: begin
                twiddle_c.re = -t_k;
                twiddle_c.im = -t_c;
            end
            Q3: begin
                twiddle_c.re = t_c;
                twiddle_c.im = -t_k;
            end
            default: begin
                twiddle_c.re = t_k;
                twiddle_c.im = t_c;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            twiddle <= '0;
        end else begin
            twiddle <= twiddle_c;
        end
    end

endmodule

/* fft_pkg.sv */
/*
 Widths, fixed point types and table constants for the radix-2 butterfly.
 The RTL modules and the testbench import this package.
*/
package fft_pkg;

    //////////////////////////////
    // widths

    // one component of an input sample
    localparam int SAMPLE_W = 16;
    // a + b and a - b need one more bit
    localparam int SUM_W    = 17;
    // y component after rescaling
    localparam int PROD_W   = 18;
    // twiddle angle in 1/256 turns
    localparam int ANGLE_W  = 8;
    // position inside one quadrant
    localparam int OFFSET_W = 6;

    // raw partial product and the sum of two of them
    localparam int MULT_W = SUM_W + SAMPLE_W;
    localparam int ACC_W  = MULT_W + 1;

    //////////////////////////////
    // twiddle table

    // quarter wave including the 90 degree point
    localparam int TABLE_DEPTH  = 65;
    localparam int TABLE_ADDR_W = $clog2(TABLE_DEPTH);
    localparam int QUARTER      = 64;
    // twiddle is Q1.15
    localparam int FRAC_BITS    = 15;

    localparam string COS_TABLE_FILE = "quarter_cos.hex";

    // input to x and y
    localparam int PIPE_LATENCY = 3;

    //////////////////////////////
    // types

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [SUM_W-1:0]    sum_t;
    typedef logic signed [PROD_W-1:0]   prod_t;
    typedef logic [ANGLE_W-1:0]         angle_t;

    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_t;

    typedef struct packed {
        sum_t re;
        sum_t im;
    } cplx_sum_t;

    typedef struct packed {
        prod_t re;
        prod_t im;
    } cplx_prod_t;

    // top two angle bits
    typedef enum logic [1:0] {
        Q0,
        Q1,
        Q2,
        Q3
    } quadrant_t;

endpackage
